// ==== design/pet_pkg.sv ====
// Shared types and constants for the PET keyboard path, with addresses taken from the PET I/O map
package pet_pkg;

    localparam logic [1:0] PIA_PORTA = 2'd0;            // Port A data / DDR
    localparam logic [1:0] PIA_CRA   = 2'd1;            // Control register A
    localparam logic [1:0] PIA_PORTB = 2'd2;            // Port B data / DDR
    localparam logic [1:0] PIA_CRB   = 2'd3;            // Control register B

    localparam logic [15:0] PIA1_BASE    = 16'hE810;    // PIA1 in the $E8xx I/O page
    localparam logic [16:0] KBD_SPI_BASE = 17'h0E800;   // Matrix window seen from SPI

    localparam int         KBD_ROWS     = 16;           // Rows in the key matrix
    localparam int         KBD_ROW_BITS = 4;            // Row index width
    localparam logic [7:0] KBD_NO_KEY   = 8'hFF;        // Active low matrix, nothing pressed

    localparam int SPI_FRAME_BYTES = 4;                 // Cmd, addr hi, addr lo, data
    localparam int SPI_FRAME_BITS  = SPI_FRAME_BYTES * 8;
    localparam int SPI_CNT_BITS    = 6;                 // Holds 0 to SPI_FRAME_BITS
    localparam int SPI_WR_FLAG     = SPI_FRAME_BITS - 1;    // Bit 7 of the command byte
    localparam int SPI_ADDR16      = SPI_FRAME_BITS - 8;    // Bit 0 of the command byte

    // Pending SPI transaction
    typedef struct packed {
        logic [16:0] addr;      // Bit 16 comes from the command byte
        logic [7:0]  data;      // Write data
        logic        wr_en;     // One-cycle strobe
    } spi_req_t;

    // Pending CPU bus transaction
    typedef struct packed {
        logic [15:0] addr;      // 6502 address
        logic [7:0]  data;      // Write data from the CPU
        logic        rd_en;     // Read strobe
        logic        wr_en;     // Write strobe
    } cpu_bus_t;

    // PIA1 select
    typedef struct packed {
        logic       en;         // Chip select
        logic [1:0] rs;         // Register select
    } pia_sel_t;

endpackage

// ==== design/spi_target.sv ====
// Write-only mode 0 SPI target clocked on the falling edge of strobe_clk_i, and SCK half-periods must span at least 4 clocks
`timescale 1ns/1ns

module spi_target (
    input  logic              strobe_clk_i,
    input  logic              rst_i,
    input  logic              spi_sck_i,     // SPI clock from the host MCU
    input  logic              spi_cs_n_i,    // Frame select, active low
    input  logic              spi_mosi_i,    // Data from host, MSB first
    output pet_pkg::spi_req_t spi_req_o      // Last completed write
);
    import pet_pkg::*;

    logic [2:0] sck_sync;                    // Two sync stages plus edge history
    logic [2:0] cs_n_sync;                   // Two sync stages plus edge history
    logic [1:0] mosi_sync;                   // Aligned with sck_sync[1]

    logic                      sck_rise;     // Sampling edge in mode 0
    logic                      cs_active;    // Frame in progress
    logic                      cs_rise;      // End of frame
    logic                      cnt_full;     // All frame bits received
    logic                      frame_last;   // This edge carries the final bit
    logic                      frame_wr;     // Completed frame is a write

    logic [SPI_CNT_BITS-1:0]   bit_cnt;      // Bits shifted in this frame
    logic [SPI_FRAME_BITS-1:0] frame_q;      // Shift register
    logic [SPI_FRAME_BITS-1:0] frame_next;   // Shift register with the incoming bit

    // Bring the pins into the strobe clock domain
    always_ff @(negedge strobe_clk_i) begin
        if (rst_i) begin
            sck_sync  <= '0;                 // SCK idles low in mode 0
            cs_n_sync <= '1;                 // Deselected
            mosi_sync <= '0;
        end else begin
            sck_sync  <= {sck_sync[1:0], spi_sck_i};
            cs_n_sync <= {cs_n_sync[1:0], spi_cs_n_i};
            mosi_sync <= {mosi_sync[0], spi_mosi_i};
        end
    end

    assign sck_rise  = sck_sync[1] && !sck_sync[2];
    assign cs_active = !cs_n_sync[1];
    assign cs_rise   = cs_n_sync[1] && !cs_n_sync[2];

    assign cnt_full   = (bit_cnt == SPI_CNT_BITS'(SPI_FRAME_BITS));
    assign frame_last = sck_rise && cs_active && (bit_cnt == SPI_CNT_BITS'(SPI_FRAME_BITS - 1));
    assign frame_next = {frame_q[SPI_FRAME_BITS-2:0], mosi_sync[1]};   // MSB first
    assign frame_wr   = frame_last && frame_next[SPI_WR_FLAG];         // Read frames are dropped

    // Bit counter stops at a full frame so that trailing clocks are ignored
    always_ff @(negedge strobe_clk_i) begin
        if (rst_i || cs_rise) begin
            bit_cnt <= '0;                   // Short frames die here
        end else if (sck_rise && cs_active && !cnt_full) begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // Frame shift register
    always_ff @(negedge strobe_clk_i) begin
        if (sck_rise && cs_active && !cnt_full) begin
            frame_q <= frame_next;
        end
    end

    // Request goes out on the edge that shifts in the last bit
    always_ff @(negedge strobe_clk_i) begin
        if (frame_wr) begin
            spi_req_o.addr <= {frame_next[SPI_ADDR16], frame_next[23:8]};  // Cmd bit 0, hi, lo
            spi_req_o.data <= frame_next[7:0];                             // Final byte
        end
        if (rst_i) begin
            spi_req_o.wr_en <= 1'b0;
        end else begin
            spi_req_o.wr_en <= frame_wr;     // Single-cycle pulse
        end
    end

endmodule

// ==== design/address_decoder.sv ====
// PIA1 select for the $E8xx I/O page, answering only the first four registers of the PIA1 block
`timescale 1ns/1ns

module address_decoder (
    input  logic [15:0]       cpu_addr_i,    // CPU bus address
    output pet_pkg::pia_sel_t pia1_sel_o     // PIA1 chip and register select
);
    import pet_pkg::*;

    logic        io_page;                    // Address falls in $E8xx
    logic        pia1_blk;                   // PIA1 block, $E81x
    logic        pia1_regs;                  // Lowest four bytes of that block

    // The PET does not decode A7..A0 fully, so the page is split on A7..A4
    assign io_page   = (cpu_addr_i[15:8] == PIA1_BASE[15:8]);
    assign pia1_blk  = io_page && (cpu_addr_i[7:4] == PIA1_BASE[7:4]);  // PIA2 and VIA sit beside it
    assign pia1_regs = (cpu_addr_i[3:2] == PIA1_BASE[3:2]);  // Mirrors above $E813 are ignored

    always_comb begin
        pia1_sel_o.en = pia1_blk && pia1_regs;
        pia1_sel_o.rs = cpu_addr_i[1:0];             // RS1 = A1, RS0 = A0
    end

endmodule

// ==== design/keyboard.sv ====
// Key matrix cache updated on the falling edge of strobe_clk_i, which overrides PIA1 port B only when a key in the row is down
`timescale 1ns/1ns

module keyboard (
    input  logic              strobe_clk_i,
    input  logic              rst_i,
    input  pet_pkg::spi_req_t spi_req_i,     // Matrix writes from the host MCU
    input  pet_pkg::pia_sel_t pia1_sel_i,    // From the address decoder
    input  pet_pkg::cpu_bus_t cpu_bus_i,     // Pending CPU access
    output logic [7:0]        kbd_data_o,    // Cached columns for the current row
    output logic              kbd_data_oe_o  // Drive the data bus instead of PIA1
);
    import pet_pkg::*;

    logic [7:0]              kbd_matrix [KBD_ROWS];  // One byte of columns per row
    logic [KBD_ROW_BITS-1:0] kbd_row;                // Row picked through port A

    logic spi_wr_matrix;                     // SPI write hits $0E800..$0E80F
    logic writing_port_a;                    // CPU selects a row
    logic reading_port_b;                    // CPU reads the columns

    assign spi_wr_matrix = spi_req_i.wr_en &&
        (spi_req_i.addr[16:KBD_ROW_BITS] == KBD_SPI_BASE[16:KBD_ROW_BITS]);

    assign writing_port_a = cpu_bus_i.wr_en && pia1_sel_i.en && (pia1_sel_i.rs == PIA_PORTA);
    assign reading_port_b = cpu_bus_i.rd_en && pia1_sel_i.en && (pia1_sel_i.rs == PIA_PORTB);

    // One action per edge, SPI first, then the row latch, otherwise refresh the output
    always_ff @(negedge strobe_clk_i) begin
        if (rst_i) begin
            for (int r = 0; r < KBD_ROWS; r++) begin
                kbd_matrix[r] <= KBD_NO_KEY;         // All keys up
            end
            kbd_row    <= '0;
            kbd_data_o <= KBD_NO_KEY;
        end else if (spi_wr_matrix) begin
            kbd_matrix[spi_req_i.addr[KBD_ROW_BITS-1:0]] <= spi_req_i.data;
        end else if (writing_port_a) begin
            kbd_row <= cpu_bus_i.data[KBD_ROW_BITS-1:0];    // Upper bits drive other PET lines
        end else begin
            kbd_data_o <= kbd_matrix[kbd_row];      // Settles one edge after a change
        end
    end

    // With no key down the read falls through to the real PIA1 and keyboard
    assign kbd_data_oe_o = reading_port_b && (kbd_data_o != KBD_NO_KEY);

endmodule

// ==== design/pet_io_top.sv ====
// Keyboard path of the PET I/O page, where every register updates on the falling edge of strobe_clk_i
`timescale 1ns/1ns

module pet_io_top (
    input  logic              strobe_clk_i,
    input  logic              rst_i,
    input  logic              spi_sck_i,     // Host MCU SPI clock
    input  logic              spi_cs_n_i,    // Host MCU frame select
    input  logic              spi_mosi_i,    // Host MCU data
    input  pet_pkg::cpu_bus_t cpu_bus_i,     // Emulated 6502 bus
    output logic [7:0]        kbd_data_o,    // Port B override data
    output logic              kbd_data_oe_o  // Port B override enable
);
    import pet_pkg::*;

    spi_req_t spi_req;                       // Latest SPI write
    pia_sel_t pia1_sel;                      // PIA1 select for the current access

    spi_target u_spi_target (
        .strobe_clk_i (strobe_clk_i),
        .rst_i        (rst_i),
        .spi_sck_i    (spi_sck_i),
        .spi_cs_n_i   (spi_cs_n_i),
        .spi_mosi_i   (spi_mosi_i),
        .spi_req_o    (spi_req)
    );

    address_decoder u_address_decoder (
        .cpu_addr_i (cpu_bus_i.addr),
        .pia1_sel_o (pia1_sel)
    );

    keyboard u_keyboard (
        .strobe_clk_i  (strobe_clk_i),
        .rst_i         (rst_i),
        .spi_req_i     (spi_req),
        .pia1_sel_i    (pia1_sel),
        .cpu_bus_i     (cpu_bus_i),
        .kbd_data_o    (kbd_data_o),
        .kbd_data_oe_o (kbd_data_oe_o)
    );

endmodule

// ==== verification/kbd_checker.sv ====
// Pin-level reference model that compares accesses only after two quiet falling edges
`timescale 1ns/1ns

module kbd_checker (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              spi_sck_i,       // Same pins the DUT sees
    input  logic              spi_cs_n_i,
    input  logic              spi_mosi_i,
    input  pet_pkg::cpu_bus_t cpu_bus_i,
    input  logic [7:0]        kbd_data_i,      // DUT port B override data
    input  logic              kbd_data_oe_i,   // DUT port B override enable
    output logic              settled_o,       // Model and DUT agree on timing
    output int                checks_o,        // Compared accesses so far
    output int                errors_o         // Mismatches and protocol faults
);
    import pet_pkg::*;

    localparam int CS_LOW_LIMIT = 4000;        // Longest legal frame is far shorter

    logic [7:0]  model_matrix [KBD_ROWS];      // Expected key matrix
    logic [3:0]  model_row;                    // Expected row latch
    logic [31:0] shift_q;                      // Frame bits seen so far
    int          bit_cnt;
    int          settle;                       // Falling edges since the last model change
    int          cs_low_cnt;
    logic        sck_prev;
    logic        cs_n_prev;

    always @(negedge clk_i) begin
        logic [16:0] waddr;
        logic        pia1_hit;
        logic        exp_oe;
        logic [7:0]  exp_data;
        if (rst_i) begin
            for (int i = 0; i < KBD_ROWS; i++) begin
                model_matrix[i] = KBD_NO_KEY;  // All keys up
            end
            model_row  = '0;
            bit_cnt    = 0;
            settle     = 0;
            cs_low_cnt = 0;
            sck_prev   = 1'b0;
            cs_n_prev  = 1'b1;
            checks_o   = 0;
            errors_o   = 0;
        end else begin
            if (settle < 1000) begin
                settle = settle + 1;
            end
            // Mode 0 sampling on SCK rise, at most one frame of bits
            if (!spi_cs_n_i && spi_sck_i && !sck_prev && bit_cnt < 32) begin
                shift_q = {shift_q[30:0], spi_mosi_i};
                bit_cnt = bit_cnt + 1;
            end
            if (spi_cs_n_i && !cs_n_prev) begin
                waddr = {shift_q[24], shift_q[23:8]};    // Cmd bit 0, then hi and lo bytes
                if (bit_cnt == 32 && shift_q[31] && waddr >= KBD_SPI_BASE &&
                    waddr <= KBD_SPI_BASE + 17'(KBD_ROWS - 1)) begin
                    model_matrix[waddr[3:0]] = shift_q[7:0];
                    settle = 0;
                end
                bit_cnt = 0;                   // Short and read frames vanish here
            end
            cs_low_cnt = spi_cs_n_i ? 0 : cs_low_cnt + 1;
            if (cs_low_cnt == CS_LOW_LIMIT) begin
                $display("SPI chip select stayed low for %0d clocks at %0t ns",
                         CS_LOW_LIMIT, $time);
                errors_o = errors_o + 1;
            end
            pia1_hit = (cpu_bus_i.addr >= PIA1_BASE) && (cpu_bus_i.addr <= PIA1_BASE + 16'd3);
            if (settle >= 2 && (cpu_bus_i.rd_en || cpu_bus_i.wr_en)) begin
                exp_data = model_matrix[model_row];
                exp_oe   = pia1_hit && cpu_bus_i.rd_en && (cpu_bus_i.addr[1:0] == PIA_PORTB) &&
                           (exp_data != KBD_NO_KEY);
                checks_o = checks_o + 1;
                if (kbd_data_oe_i !== exp_oe || (exp_oe && kbd_data_i !== exp_data)) begin
                    // Values shown as oe/data
                    $display("[FAIL] %0t ns: addr %04h row %0d got %0b/%02h expected %0b/%02h",
                             $time, cpu_bus_i.addr, model_row, kbd_data_oe_i, kbd_data_i,
                             exp_oe, exp_data);
                    errors_o = errors_o + 1;
                end
            end
            // Row latch follows the port A write after the compare
            if (pia1_hit && cpu_bus_i.wr_en && cpu_bus_i.addr[1:0] == PIA_PORTA) begin
                model_row = cpu_bus_i.data[3:0];
                settle    = 0;
            end
            sck_prev  = spi_sck_i;
            cs_n_prev = spi_cs_n_i;
        end
    end

    assign settled_o = (settle >= 2);

endmodule

// ==== verification/kbd_asserts.sv ====
// Properties sampled on the rising strobe edge, halfway between the keyboard's falling-edge updates
`timescale 1ns/1ns

module kbd_asserts (
    input logic              clk_i,
    input logic              rst_i,
    input logic [7:0]        kbd_data_i,      // Cached row
    input logic              kbd_data_oe_i,   // Override enable
    input pet_pkg::cpu_bus_t cpu_bus_i,       // CPU access seen by the keyboard
    input logic              spi_wr_en_i      // SPI write strobe
);
    import pet_pkg::*;

    int   fail_cnt = 0;                // Failed assertions so far
    logic port_b_rd;                   // Port B read taken from the full address

    assign port_b_rd = cpu_bus_i.rd_en && (cpu_bus_i.addr == PIA1_BASE + 16'(PIA_PORTB));

    oe_needs_read: assert property (@(posedge clk_i) disable iff (rst_i)
        kbd_data_oe_i |-> port_b_rd)
    else begin
        fail_cnt++;
        $error("override enable high without a port B read");
    end

    oe_on_key: assert property (@(posedge clk_i) disable iff (rst_i)
        (port_b_rd && (kbd_data_i != KBD_NO_KEY)) |-> kbd_data_oe_i)
    else begin
        fail_cnt++;
        $error("port B read with a key pressed left the override enable low");
    end

    reset_values: assert property (@(posedge clk_i)
        $fell(rst_i) |-> (kbd_data_i == KBD_NO_KEY) && !kbd_data_oe_i)
    else begin
        fail_cnt++;
        $error("keyboard outputs not at reset values after reset");
    end

    wr_en_single: assert property (@(posedge clk_i) disable iff (rst_i)
        spi_wr_en_i |=> !spi_wr_en_i)
    else begin
        fail_cnt++;
        $error("SPI write strobe high for two cycles");
    end

endmodule

bind keyboard kbd_asserts u_kbd_asserts (
    .clk_i         (strobe_clk_i),
    .rst_i         (rst_i),
    .kbd_data_i    (kbd_data_o),
    .kbd_data_oe_i (kbd_data_oe_o),
    .cpu_bus_i     (cpu_bus_i),
    .spi_wr_en_i   (spi_req_i.wr_en)
);

// ==== verification/tb_top.sv ====
// Fixed-seed run that bit-bangs SPI with 4-clock SCK half-periods and never overlaps SPI frames with CPU strobes
`timescale 1ns/1ns

module tb_top;
    import pet_pkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int HALF_SCK     = 4;        // Strobe clocks per SCK half-period
    localparam int SETTLE_LIMIT = 40;       // Clocks allowed for the model to settle
    localparam int RUN_LIMIT    = 200000;   // Whole-run watchdog in clocks
    localparam int MIX_OPS      = 500;

    logic       clk;
    logic       rst;
    logic       spi_sck;
    logic       spi_cs_n;
    logic       spi_mosi;
    cpu_bus_t   cpu_bus;
    logic [7:0] kbd_data;
    logic       kbd_data_oe;

    logic settled;                          // Checker model is stable
    int   checks;
    int   errors;
    int   assert_fails;
    int   tests_passed;
    int   tests_failed;
    int   checks_mark;                      // Counts at the start of the current test
    int   errors_mark;

    pet_io_top DUT (
        .strobe_clk_i  (clk),
        .rst_i         (rst),
        .spi_sck_i     (spi_sck),
        .spi_cs_n_i    (spi_cs_n),
        .spi_mosi_i    (spi_mosi),
        .cpu_bus_i     (cpu_bus),
        .kbd_data_o    (kbd_data),
        .kbd_data_oe_o (kbd_data_oe)
    );

    kbd_checker u_kbd_checker (
        .clk_i         (clk),
        .rst_i         (rst),
        .spi_sck_i     (spi_sck),
        .spi_cs_n_i    (spi_cs_n),
        .spi_mosi_i    (spi_mosi),
        .cpu_bus_i     (cpu_bus),
        .kbd_data_i    (kbd_data),
        .kbd_data_oe_i (kbd_data_oe),
        .settled_o     (settled),
        .checks_o      (checks),
        .errors_o      (errors)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;             // 20 ns period
    end

    initial begin
        repeat (RUN_LIMIT) @(posedge clk);
        $display("Timeout: the run did not finish within %0d clocks", RUN_LIMIT);
        $display("Simulation failed");
        $finish;
    end

    task automatic cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    // Holds off until the model has seen two quiet falling edges
    task automatic wait_settled();
        int waited;
        waited = 0;
        while (!settled && waited < SETTLE_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (!settled) begin
            $display("Timeout: checker model did not settle within %0d clocks at %0t ns",
                     SETTLE_LIMIT, $time);
            $display("Simulation failed");
            $finish;
        end
    endtask

    function automatic logic [31:0] make_frame(input logic wr, input logic [16:0] addr,
                                               input logic [7:0] data);
        return {wr, 6'b0, addr[16], addr[15:8], addr[7:0], data};   // Cmd, hi, lo, data
    endfunction

    // Mode 0, MSB first, only the first nbits of the frame
    task automatic send_frame(input logic [31:0] frame, input int nbits);
        int b;
        spi_cs_n <= 1'b0;
        for (b = 0; b < nbits; b++) begin
            spi_mosi <= frame[31 - b];      // Data changes while SCK is low
            cycles(HALF_SCK);
            spi_sck <= 1'b1;
            cycles(HALF_SCK);
            spi_sck <= 1'b0;
        end
        cycles(HALF_SCK);
        spi_cs_n <= 1'b1;
        cycles(HALF_SCK);
        wait_settled();
    endtask

    task automatic spi_write(input logic [16:0] addr, input logic [7:0] data);
        send_frame(make_frame(1'b1, addr, data), 32);
    endtask

    // One-cycle CPU strobe followed by an idle bus
    task automatic cpu_access(input logic [15:0] addr, input logic [7:0] data,
                              input logic rd, input logic wr);
        wait_settled();
        cpu_bus <= {addr, data, rd, wr};
        cycles(1);
        cpu_bus <= '0;
        cycles(1);
    endtask

    task automatic read_row(input logic [3:0] row);
        cpu_access(PIA1_BASE + 16'(PIA_PORTA), {4'($urandom), row}, 1'b0, 1'b1);
        cpu_access(PIA1_BASE + 16'(PIA_PORTB), 8'h00, 1'b1, 1'b0);
    endtask

    function automatic logic [7:0] rand_row_byte();
        return ($urandom_range(3) == 0) ? KBD_NO_KEY : 8'($urandom);   // Some rows idle
    endfunction

    // Half the picks land on PIA1, the rest on the I/O page or anywhere
    function automatic logic [15:0] rand_cpu_addr();
        case ($urandom_range(3))
            0, 1:    return PIA1_BASE + 16'($urandom_range(3));
            2:       return {8'hE8, 8'($urandom)};
            default: return 16'($urandom);
        endcase
    endfunction

    function automatic logic [16:0] rand_outside_addr();
        logic [16:0] a;
        case ($urandom_range(2))
            0:       a = {1'b1, 16'hE800 + 16'($urandom_range(15))};   // Bit 16 alias
            1:       a = 17'h0E810 + 17'($urandom_range(255));         // Just above the window
            default: a = 17'($urandom);
        endcase
        if (a >= KBD_SPI_BASE && a <= KBD_SPI_BASE + 17'(KBD_ROWS - 1)) begin
            a[16] = 1'b1;
        end
        return a;
    endfunction

    task automatic end_test(input string name);
        int new_checks;
        int new_errors;
        new_checks = checks - checks_mark;
        new_errors = errors - errors_mark;
        if (new_errors == 0 && new_checks > 0) begin
            tests_passed++;
            $display("test %s: passed, %0d checks", name, new_checks);
        end else begin
            tests_failed++;
            $display("test %s: failed, %0d checks, %0d errors", name, new_checks, new_errors);
        end
        checks_mark = checks;
        errors_mark = errors;
    endtask

    initial begin
        int          r;
        int          n;
        logic        rd;
        logic [15:0] a;
        void'($urandom(32'h1006_9827));     // One seed for the whole run
        rst          = 1'b1;
        spi_sck      = 1'b0;
        spi_cs_n     = 1'b1;
        spi_mosi     = 1'b0;
        cpu_bus      = '0;
        tests_passed = 0;
        tests_failed = 0;
        cycles(RESET_CYCLES);
        rst <= 1'b0;
        cycles(4);
        checks_mark = checks;
        errors_mark = errors;

        for (r = 0; r < KBD_ROWS; r++) begin
            read_row(4'(r));
        end
        end_test("reset state");

        for (r = 0; r < KBD_ROWS; r++) begin
            spi_write(KBD_SPI_BASE + 17'(r), rand_row_byte());
        end
        for (r = 0; r < KBD_ROWS; r++) begin
            read_row(4'(r));
        end
        end_test("matrix write and read");

        for (n = 0; n < 4; n++) begin
            r = $urandom_range(15);
            spi_write(KBD_SPI_BASE + 17'(r), 8'($urandom) & 8'h7F);
            read_row(4'(r));
            spi_write(KBD_SPI_BASE + 17'(r), KBD_NO_KEY);               // Release the row
            read_row(4'(r));
        end
        end_test("key release");

        for (n = 0; n < 8; n++) begin
            r = $urandom_range(15);
            send_frame(make_frame(1'b1, KBD_SPI_BASE + 17'(r), 8'h00), int'($urandom_range(31, 1)));
            send_frame(make_frame(1'b0, KBD_SPI_BASE + 17'(r), 8'h00), 32);
            spi_write(rand_outside_addr(), 8'h00);
        end
        for (r = 0; r < KBD_ROWS; r++) begin
            read_row(4'(r));
        end
        end_test("ignored frames");

        for (r = 0; r < KBD_ROWS; r++) begin
            spi_write(KBD_SPI_BASE + 17'(r), 8'($urandom) & 8'hFE);     // Keys down everywhere
        end
        for (n = 0; n < 100; n++) begin
            a  = rand_cpu_addr();
            rd = 1'($urandom_range(1));
            if (a == PIA1_BASE + 16'(PIA_PORTB)) begin
                rd = 1'b0;
            end
            cpu_access(a, 8'($urandom), rd, !rd);
        end
        end_test("other registers");

        for (n = 0; n < MIX_OPS; n++) begin
            case ($urandom_range(9))
                0, 1:    spi_write(KBD_SPI_BASE + 17'($urandom_range(15)), rand_row_byte());
                2:       spi_write(rand_outside_addr(), 8'($urandom));
                3, 4:    cpu_access(PIA1_BASE + 16'(PIA_PORTA), 8'($urandom), 1'b0, 1'b1);
                5, 6, 7: cpu_access(PIA1_BASE + 16'(PIA_PORTB), 8'h00, 1'b1, 1'b0);
                default: begin
                    rd = 1'($urandom_range(1));
                    cpu_access(rand_cpu_addr(), 8'($urandom), rd, !rd);
                end
            endcase
        end
        end_test("random mix");

        assert_fails = DUT.u_keyboard.u_kbd_asserts.fail_cnt;
        $display("tests passed %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
                 tests_passed, tests_failed, checks, errors, assert_fails);
        if (tests_failed == 0 && errors == 0 && assert_fails == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
design/pet_pkg.sv
design/spi_target.sv
design/address_decoder.sv
design/keyboard.sv
design/pet_io_top.sv
verification/kbd_checker.sv
verification/kbd_asserts.sv
verification/tb_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
RUN_FLAGS ?= +verilator+error+limit+1000
LOG       ?= sim.log
PASS_MSG  := Simulation completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and search the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Result: PASS"; \
	else \
		echo "Result: FAIL, pass message not found in $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
